/* all.f */
common/cipher_ctrl_pkg.sv
design/cipher_ctrl/cipher_cmd_reg.sv
design/cipher_ctrl/cipher_rnd_ctr.sv
design/cipher_ctrl/cipher_key_sel.sv
design/cipher_ctrl/cipher_ctrl_fsm.sv
design/cipher_ctrl_top.sv
verif/tb_clk_gen.sv
verif/tb_cipher_ctrl.sv

/* Makefile */
# Verilator build for the cipher control testbench

VERILATOR ?= verilator
TOP       ?= tb_cipher_ctrl
RTL_TOP   ?= cipher_ctrl_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_cipher_ctrl.sv */
////////////////////////////////////////
// Cipher control testbench
// Datapath responder, reference decode,
// compare process and watchdog
////////////////////////////////////////

module tb_cipher_ctrl import cipher_ctrl_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS    = 100;
  localparam int WD_CMDS   = 40;
  localparam int WD_CYCLES = 40;
  localparam int MAX_WAIT  = 400;

  // Operation kinds tracked by the compare process
  localparam int MODE_CRYPT  = 0;
  localparam int MODE_KEYGEN = 1;
  localparam int MODE_CLEAR  = 2;

  typedef struct packed {
    key_words_sel_e words;
    round_key_sel_e rkey;
    key_full_sel_e  full;
  } exp_sel_t;

  logic                 clk_i, gen_rst_n, tb_rst_n, rst_ni;
  logic                 in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  logic                 sub_bytes_out_req_i, key_expand_out_req_i, alert_fatal_i, alert_o;
  cipher_cmd_t          cmd_i;
  state_ctrl_t          state_ctrl_o;
  key_ctrl_t            key_ctrl_o;
  logic [RND_CTR_W-1:0] rnd_ctr_o;

  int          seed = 32'h3c10_27f3;
  logic        err_mode;
  key_len_e    kls [3] = '{AES_128, AES_192, AES_256};

  assign rst_ni = gen_rst_n & tb_rst_n;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(gen_rst_n));

  cipher_ctrl_top u_cipher_ctrl_top (
    .clk_i, .rst_ni, .in_valid_i, .in_ready_o, .cmd_i, .out_valid_o, .out_ready_i,
    .sub_bytes_out_req_i, .key_expand_out_req_i, .alert_fatal_i,
    .state_ctrl_o, .key_ctrl_o, .rnd_ctr_o, .alert_o
  );

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  // Selector table by operation, key length and phase
  function automatic exp_sel_t expected_sel(ciph_op_e op, key_len_e kl, key_phase_e ph);
    exp_sel_t e;
    logic     inv;
    inv     = (op == CIPH_INV);
    e.words = KEY_WORDS_ZERO;
    if (ph == KEY_PHASE_INIT) begin
      if (kl == AES_128 || !inv) e.words = KEY_WORDS_0123;
      else if (kl == AES_192)    e.words = KEY_WORDS_2345;
      else                       e.words = KEY_WORDS_4567;
    end else if (ph == KEY_PHASE_ROUND) begin
      if (kl == AES_128 || inv)  e.words = KEY_WORDS_0123;
      else if (kl == AES_192)    e.words = KEY_WORDS_2345;
      else                       e.words = KEY_WORDS_4567;
    end
    e.rkey = inv ? ROUND_KEY_MIXED : ROUND_KEY_DIRECT;
    e.full = inv ? KEY_FULL_DEC_INIT : KEY_FULL_ENC_INIT;
    return e;
  endfunction

  // AES rounds per key length
  function automatic logic [RND_CTR_W-1:0] round_count(key_len_e kl);
    if (kl == AES_128) return 4'd10;
    if (kl == AES_192) return 4'd12;
    return 4'd14;
  endfunction

  task automatic report_fail(string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_words(string name, key_words_sel_e got, key_words_sel_e exp);
    if (got !== exp) report_fail($sformatf("MISMATCH at %0t: %s got %s expected %s",
                                           $time, name, got.name(), exp.name()));
  endtask

  task automatic check_rkey(string name, round_key_sel_e got, round_key_sel_e exp);
    if (got !== exp) report_fail($sformatf("MISMATCH at %0t: %s got %s expected %s",
                                           $time, name, got.name(), exp.name()));
  endtask

  task automatic check_full(string name, key_full_sel_e got, key_full_sel_e exp);
    if (got !== exp) report_fail($sformatf("MISMATCH at %0t: %s got %s expected %s",
                                           $time, name, got.name(), exp.name()));
  endtask

  task automatic check_ctr(string name, logic [RND_CTR_W-1:0] got,
                           logic [RND_CTR_W-1:0] exp);
    if (got !== exp) report_fail($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                                           $time, name, got, exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) report_fail($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                           $time, name, got, exp));
  endtask

  ////////////////////////////////////////
  // Datapath responder
  ////////////////////////////////////////

  logic        wr_seen, acc_seen, sb_ack_seen, ke_ack_seen, rst_seen, resp_armed;
  int unsigned resp_delay;

  always @(negedge clk_i) begin
    rst_seen    = rst_ni;
    wr_seen     = state_ctrl_o.state_we | key_ctrl_o.key_full_we;
    acc_seen    = in_valid_i & in_ready_o;
    sb_ack_seen = state_ctrl_o.sub_bytes_out_ack;
    ke_ack_seen = key_ctrl_o.key_expand_out_ack;
  end

  // Strobes rise 0 to 3 cycles after a write and drop on acknowledge
  always @(posedge clk_i) begin
    #10;
    if (!rst_seen) begin
      sub_bytes_out_req_i  = 1'b0;
      key_expand_out_req_i = 1'b0;
      resp_armed           = 1'b0;
    end else begin
      if (acc_seen || sb_ack_seen) sub_bytes_out_req_i = 1'b0;
      if (acc_seen || ke_ack_seen) key_expand_out_req_i = 1'b0;
      if (wr_seen) begin
        resp_armed = 1'b1;
        resp_delay = $unsigned($random(seed)) % 4;
      end
      if (resp_armed) begin
        if (resp_delay == 0) begin
          sub_bytes_out_req_i  = 1'b1;
          key_expand_out_req_i = 1'b1;
          resp_armed           = 1'b0;
        end else begin
          resp_delay--;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  logic        busy, hold_valid, seen_valid, in_init;
  int          mode, dec_cnt, clr_cnt;
  cipher_cmd_t act_cmd;
  exp_sel_t    exp_s;
  key_phase_e  phase;

  always @(negedge clk_i) begin
    if (!rst_ni || err_mode) begin
      busy       = 1'b0;
      hold_valid = 1'b0;
    end else if (busy) begin
      check_bit("in_ready_o", in_ready_o, 1'b0);
      // Back-pressure must not drop a pending completion
      if (hold_valid) check_bit("out_valid_o", out_valid_o, 1'b1);
      if (mode == MODE_CRYPT) begin
        phase = in_init ? KEY_PHASE_INIT : KEY_PHASE_ROUND;
        exp_s = expected_sel(act_cmd.op, act_cmd.key_len, phase);
        check_words("key_words_sel", key_ctrl_o.key_words_sel, exp_s.words);
        check_rkey("round_key_sel", key_ctrl_o.round_key_sel, exp_s.rkey);
        // Initial round ends at once for AES-256, else on the KeyExpand strobe
        if (act_cmd.key_len == AES_256 || key_expand_out_req_i) in_init = 1'b0;
      end else if (mode == MODE_KEYGEN) begin
        check_words("key_words_sel", key_ctrl_o.key_words_sel, KEY_WORDS_ZERO);
        check_bit("state_we", state_ctrl_o.state_we, 1'b0);
        if (key_ctrl_o.key_dec_we) begin
          // Only on the first rise of out_valid_o
          check_bit("out_valid_o", out_valid_o, 1'b1);
          check_bit("out_valid_o first rise", seen_valid, 1'b0);
          dec_cnt++;
        end
      end else begin
        if (state_ctrl_o.state_we) begin
          check_bit("state_sel clear", state_ctrl_o.state_sel == STATE_CLEAR, 1'b1);
          check_bit("out_valid_o", out_valid_o, 1'b0);
          clr_cnt++;
        end
        if (act_cmd.key_clear && out_valid_o) begin
          check_bit("key_full_we", key_ctrl_o.key_full_we, 1'b1);
          check_bit("key_dec_we", key_ctrl_o.key_dec_we, 1'b1);
          check_full("key_full_sel", key_ctrl_o.key_full_sel, KEY_FULL_CLEAR);
          check_bit("key_dec_sel clear", key_ctrl_o.key_dec_sel == KEY_DEC_CLEAR, 1'b1);
        end
      end
      if (out_valid_o) seen_valid = 1'b1;
      hold_valid = out_valid_o & ~out_ready_i;
      // Transfer cycle closes the operation
      if (out_valid_o && out_ready_i) begin
        if (mode == MODE_CRYPT) begin
          check_ctr("rnd_ctr_o", rnd_ctr_o, round_count(act_cmd.key_len));
        end else if (mode == MODE_KEYGEN) begin
          check_bit("single key_dec_we", dec_cnt == 1, 1'b1);
        end else if (act_cmd.data_out_clear) begin
          check_bit("single clear state_we", clr_cnt == 1, 1'b1);
        end
        busy = 1'b0;
      end
    end else if (in_valid_i && in_ready_o) begin
      act_cmd = cmd_i;
      if (cmd_i.key_clear || cmd_i.data_out_clear) begin
        mode = MODE_CLEAR;
      end else if (cmd_i.dec_key_gen) begin
        mode = MODE_KEYGEN;
        check_full("key_full_sel", key_ctrl_o.key_full_sel, KEY_FULL_ENC_INIT);
      end else begin
        mode  = MODE_CRYPT;
        exp_s = expected_sel(cmd_i.op, cmd_i.key_len, KEY_PHASE_NONE);
        check_full("key_full_sel", key_ctrl_o.key_full_sel, exp_s.full);
      end
      dec_cnt    = 0;
      clr_cnt    = 0;
      seen_valid = 1'b0;
      hold_valid = 1'b0;
      in_init    = 1'b1;
      busy       = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic step();
    @(posedge clk_i);
    #10;
  endtask

  function automatic cipher_cmd_t make_cmd(logic crypt, logic kgen, logic kclr,
                                           logic dclr, ciph_op_e op, key_len_e kl);
    cipher_cmd_t c;
    c = '{crypt: crypt, dec_key_gen: kgen, key_clear: kclr, data_out_clear: dclr,
          op: op, key_len: kl};
    return c;
  endfunction

  // One command up to its completion transfer, with random back-pressure
  task automatic run_cmd(cipher_cmd_t c);
    int   cycles;
    logic done;
    cmd_i      = c;
    in_valid_i = 1'b1;
    @(negedge clk_i);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    step();
    in_valid_i = 1'b0;
    done       = 1'b0;
    cycles     = 0;
    while (!done) begin
      out_ready_i = ($random(seed) & 3) != 0;
      @(negedge clk_i);
      done = out_valid_o & out_ready_i;
      cycles++;
      if (cycles > MAX_WAIT) report_fail("Command did not complete within its wait limit");
      step();
    end
    out_ready_i = 1'b0;
  endtask

  // Terminal error, alert high and no new command accepted
  task automatic expect_error_hold();
    repeat (6) begin
      @(negedge clk_i);
      check_bit("alert_o", alert_o, 1'b1);
      check_bit("in_ready_o", in_ready_o, 1'b0);
      step();
    end
  endtask

  task automatic pulse_reset();
    tb_rst_n = 1'b0;
    repeat (2) step();
    tb_rst_n = 1'b1;
    step();
  endtask

  // Watchdog sized on the command budget
  initial begin
    #(WD_CMDS * WD_CYCLES * CLK_NS);
    report_fail("Watchdog expired, the run hung and did not finish in time");
  end

  initial begin
    in_valid_i           = 1'b0;
    out_ready_i          = 1'b0;
    alert_fatal_i        = 1'b0;
    tb_rst_n             = 1'b1;
    err_mode             = 1'b0;
    sub_bytes_out_req_i  = 1'b0;
    key_expand_out_req_i = 1'b0;
    cmd_i                = '{op: CIPH_FWD, key_len: AES_128, default: 1'b0};
    wait (rst_ni === 1'b1);
    step();

    // Encryption and decryption for all key lengths
    foreach (kls[i]) begin
      run_cmd(make_cmd(1'b1, 1'b0, 1'b0, 1'b0, CIPH_FWD, kls[i]));
      run_cmd(make_cmd(1'b1, 1'b0, 1'b0, 1'b0, CIPH_INV, kls[i]));
    end
    // Decryption start key generation
    foreach (kls[i]) begin
      run_cmd(make_cmd(1'b0, 1'b1, 1'b0, 1'b0, CIPH_INV, kls[i]));
    end
    // Clear commands
    run_cmd(make_cmd(1'b0, 1'b0, 1'b0, 1'b1, CIPH_FWD, AES_128));
    run_cmd(make_cmd(1'b0, 1'b0, 1'b1, 1'b0, CIPH_FWD, AES_128));
    run_cmd(make_cmd(1'b1, 1'b0, 1'b1, 1'b1, CIPH_INV, AES_256));

    // Command with no flag set
    err_mode   = 1'b1;
    cmd_i      = make_cmd(1'b0, 1'b0, 1'b0, 1'b0, CIPH_FWD, AES_128);
    in_valid_i = 1'b1;
    step();
    in_valid_i = 1'b0;
    expect_error_hold();
    pulse_reset();

    // External fatal alert in the middle of an encryption
    cmd_i      = make_cmd(1'b1, 1'b0, 1'b0, 1'b0, CIPH_FWD, AES_192);
    in_valid_i = 1'b1;
    step();
    in_valid_i = 1'b0;
    repeat (3) step();
    alert_fatal_i = 1'b1;
    step();
    alert_fatal_i = 1'b0;
    expect_error_hold();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* verif/tb_clk_gen.sv */
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam time CLK_PERIOD = 100ns;
  localparam int  RST_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset released just after a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #10 rst_no = 1'b1;
  end

endmodule

/* design/cipher_ctrl_top.sv */
////////////////////////////////////////
// Cipher control top
// FSM with command, counter, key select
////////////////////////////////////////

module cipher_ctrl_top import cipher_ctrl_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  cipher_cmd_t          cmd_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  input  logic                 sub_bytes_out_req_i,
  input  logic                 key_expand_out_req_i,
  input  logic                 alert_fatal_i,
  output state_ctrl_t          state_ctrl_o,
  output key_ctrl_t            key_ctrl_o,
  output logic [RND_CTR_W-1:0] rnd_ctr_o,
  output logic                 alert_o
);

  cipher_cmd_t    cmd_q;
  logic           cmd_load, cmd_done;
  logic           rnd_start, rnd_inc, last_round, rnd_err;
  key_phase_e     key_phase;
  key_words_sel_e key_words_sel;
  round_key_sel_e round_key_sel;
  key_full_sel_e  key_full_init_sel;

  cipher_ctrl_fsm u_fsm (
    .clk_i, .rst_ni, .in_valid_i, .in_ready_o, .cmd_i,
    .cmd_q_i             (cmd_q),
    .out_valid_o, .out_ready_i, .sub_bytes_out_req_i, .key_expand_out_req_i,
    .alert_fatal_i,
    .last_round_i        (last_round),
    .rnd_err_i           (rnd_err),
    .key_words_sel_i     (key_words_sel),
    .round_key_sel_i     (round_key_sel),
    .key_full_init_sel_i (key_full_init_sel),
    .cmd_load_o          (cmd_load),
    .cmd_done_o          (cmd_done),
    .rnd_start_o         (rnd_start),
    .rnd_inc_o           (rnd_inc),
    .key_phase_o         (key_phase),
    .state_ctrl_o, .key_ctrl_o, .alert_o
  );

  cipher_cmd_reg u_cmd_reg (
    .clk_i, .rst_ni, .cmd_i,
    .cmd_load_i (cmd_load),
    .cmd_done_i (cmd_done),
    .cmd_q_o    (cmd_q)
  );

  // Round count comes from the command being accepted
  cipher_rnd_ctr u_rnd_ctr (
    .clk_i, .rst_ni,
    .key_len_i    (cmd_i.key_len),
    .rnd_start_i  (rnd_start),
    .rnd_inc_i    (rnd_inc),
    .rnd_ctr_o,
    .last_round_o (last_round),
    .rnd_err_o    (rnd_err)
  );

  cipher_key_sel u_key_sel (
    .op_i                (cmd_q.op),
    .key_len_i           (cmd_q.key_len),
    .key_phase_i         (key_phase),
    .key_words_sel_o     (key_words_sel),
    .round_key_sel_o     (round_key_sel),
    .key_full_init_sel_o (key_full_init_sel)
  );

endmodule

/* design/cipher_ctrl/cipher_ctrl_fsm.sv */
////////////////////////////////////////
// Cipher control FSM
// Sequences load, rounds, finish, clear
// and the terminal error state
////////////////////////////////////////

module cipher_ctrl_fsm import cipher_ctrl_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  // Command handshake
  input  logic           in_valid_i,
  output logic           in_ready_o,
  input  cipher_cmd_t    cmd_i,
  input  cipher_cmd_t    cmd_q_i,
  // Completion handshake
  output logic           out_valid_o,
  input  logic           out_ready_i,
  // Datapath strobes
  input  logic           sub_bytes_out_req_i,
  input  logic           key_expand_out_req_i,
  input  logic           alert_fatal_i,
  // Round counter
  input  logic           last_round_i,
  input  logic           rnd_err_i,
  // Key selectors
  input  key_words_sel_e key_words_sel_i,
  input  round_key_sel_e round_key_sel_i,
  input  key_full_sel_e  key_full_init_sel_i,
  // Strobes to the helper blocks
  output logic           cmd_load_o,
  output logic           cmd_done_o,
  output logic           rnd_start_o,
  output logic           rnd_inc_o,
  output key_phase_e     key_phase_o,
  // Datapath control
  output state_ctrl_t    state_ctrl_o,
  output key_ctrl_t      key_ctrl_o,
  output logic           alert_o
);

  cipher_state_e state_d, state_q;
  logic          advance;
  logic          key_gen;

  // Key generation runs without touching the state
  assign key_gen = cmd_q_i.dec_key_gen;

  always_comb begin
    state_d      = state_q;
    in_ready_o   = 1'b0;
    out_valid_o  = 1'b0;
    cmd_load_o   = 1'b0;
    cmd_done_o   = 1'b0;
    rnd_start_o  = 1'b0;
    rnd_inc_o    = 1'b0;
    key_phase_o  = KEY_PHASE_NONE;
    alert_o      = 1'b0;
    advance      = 1'b0;
    // Datapath defaults
    state_ctrl_o = '{state_sel: STATE_ROUND, add_rk_sel: ADD_RK_ROUND, default: 1'b0};
    key_ctrl_o   = '{key_full_sel: KEY_FULL_ROUND, key_dec_sel: KEY_DEC_EXPAND,
                     key_words_sel: KEY_WORDS_ZERO, round_key_sel: ROUND_KEY_DIRECT,
                     default: 1'b0};

    unique case (state_q)
      CIPHER_IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          cmd_load_o = 1'b1;
          if (cmd_i.key_clear || cmd_i.data_out_clear) begin
            // Data output clear needs a cleared state first
            state_d = cmd_i.data_out_clear ? CIPHER_CLEAR_S : CIPHER_CLEAR_KD;
          end else if (cmd_i.crypt || cmd_i.dec_key_gen) begin
            // Load input data, or clear state for key generation
            state_ctrl_o.state_sel   = cmd_i.dec_key_gen ? STATE_CLEAR : STATE_INIT;
            state_ctrl_o.state_we    = 1'b1;
            key_ctrl_o.key_expand_clear = 1'b1;
            // Full key, always the encryption key for key generation
            key_ctrl_o.key_full_sel  = (cmd_i.dec_key_gen || cmd_i.op == CIPH_FWD) ?
                                       KEY_FULL_ENC_INIT : KEY_FULL_DEC_INIT;
            key_ctrl_o.key_full_we   = 1'b1;
            rnd_start_o = 1'b1;
            state_d     = CIPHER_INIT;
          end else begin
            // Handshake without any command flag
            state_d = CIPHER_ERROR;
          end
        end
      end

      CIPHER_INIT: begin
        key_phase_o = key_gen ? KEY_PHASE_NONE : KEY_PHASE_INIT;
        state_ctrl_o.add_rk_sel = ADD_RK_INIT;
        // AES-256 has its first two round keys ready at once
        if (cmd_q_i.key_len != AES_256) begin
          key_ctrl_o.key_expand_en = 1'b1;
          advance = key_expand_out_req_i;
          key_ctrl_o.key_expand_out_ack = advance;
          key_ctrl_o.key_full_we = advance;
        end else begin
          advance = 1'b1;
        end
        if (advance) begin
          state_ctrl_o.state_we = ~key_gen;
          rnd_inc_o = 1'b1;
          state_d   = CIPHER_ROUND;
        end
      end

      CIPHER_ROUND: begin
        key_phase_o = key_gen ? KEY_PHASE_NONE : KEY_PHASE_ROUND;
        state_ctrl_o.sub_bytes_en = ~key_gen;
        key_ctrl_o.key_expand_en  = 1'b1;
        // Wait for KeyExpand, and SubBytes unless generating a key
        advance = key_expand_out_req_i & (key_gen | sub_bytes_out_req_i);
        if (advance) begin
          state_ctrl_o.sub_bytes_out_ack = ~key_gen;
          state_ctrl_o.state_we          = ~key_gen;
          key_ctrl_o.key_expand_out_ack  = 1'b1;
          key_ctrl_o.key_full_we         = 1'b1;
          rnd_inc_o = 1'b1;
          if (last_round_i) begin
            state_d = CIPHER_FINISH;
            if (key_gen) begin
              // Decryption start key ready, try to hand over right away
              key_ctrl_o.key_dec_we = 1'b1;
              out_valid_o = 1'b1;
              if (out_ready_i) begin
                cmd_done_o = 1'b1;
                state_d    = CIPHER_IDLE;
              end
            end
          end
        end
      end

      CIPHER_FINISH: begin
        key_phase_o = key_gen ? KEY_PHASE_NONE : KEY_PHASE_ROUND;
        // Final round skips MixColumns
        state_ctrl_o.add_rk_sel   = ADD_RK_FINAL;
        state_ctrl_o.state_sel    = STATE_CLEAR;
        state_ctrl_o.sub_bytes_en = ~key_gen;
        out_valid_o = key_gen | sub_bytes_out_req_i;
        if (out_valid_o && out_ready_i) begin
          // Output taken, wipe the state
          state_ctrl_o.sub_bytes_out_ack = ~key_gen;
          state_ctrl_o.state_we          = ~key_gen;
          cmd_done_o = 1'b1;
          state_d    = CIPHER_IDLE;
        end
      end

      CIPHER_CLEAR_S: begin
        state_ctrl_o.state_sel = STATE_CLEAR;
        state_ctrl_o.state_we  = 1'b1;
        state_d = CIPHER_CLEAR_KD;
      end

      CIPHER_CLEAR_KD: begin
        if (cmd_q_i.key_clear) begin
          key_ctrl_o.key_full_sel = KEY_FULL_CLEAR;
          key_ctrl_o.key_full_we  = 1'b1;
          key_ctrl_o.key_dec_sel  = KEY_DEC_CLEAR;
          key_ctrl_o.key_dec_we   = 1'b1;
        end
        // Cleared state passes through to the data output
        if (cmd_q_i.data_out_clear) begin
          state_ctrl_o.add_rk_sel = ADD_RK_INIT;
        end
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          cmd_done_o = 1'b1;
          state_d    = CIPHER_IDLE;
        end
      end

      CIPHER_ERROR: begin
        alert_o = 1'b1;
      end

      default: begin
        alert_o = 1'b1;
        state_d = CIPHER_ERROR;
      end
    endcase

    // Word and round-key selection follow the phase
    key_ctrl_o.key_words_sel = key_words_sel_i;
    if (key_phase_o != KEY_PHASE_NONE) begin
      key_ctrl_o.round_key_sel = round_key_sel_i;
    end

    // Counter fault or external alert is terminal
    if (rnd_err_i || alert_fatal_i) begin
      state_d = CIPHER_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CIPHER_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  a_state_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {CIPHER_IDLE, CIPHER_INIT, CIPHER_ROUND, CIPHER_FINISH,
                    CIPHER_CLEAR_S, CIPHER_CLEAR_KD, CIPHER_ERROR});

  // Completion stays offered until taken, unless an error cuts in
  a_out_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i && !alert_fatal_i && !rnd_err_i) |=> out_valid_o);

  a_ready_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_ready_o |-> state_q == CIPHER_IDLE);

  // Full key loaded on acceptance agrees with the held command's decode
  a_full_key_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == CIPHER_INIT && $past(state_q) == CIPHER_IDLE && !key_gen) |->
      $past(key_ctrl_o.key_full_sel) == key_full_init_sel_i);

endmodule

/* design/cipher_ctrl/cipher_key_sel.sv */
////////////////////////////////////////
// Key selector decode
// Key words, round key and initial key
////////////////////////////////////////

module cipher_key_sel import cipher_ctrl_pkg::*; (
  input  ciph_op_e       op_i,
  input  key_len_e       key_len_i,
  input  key_phase_e     key_phase_i,
  output key_words_sel_e key_words_sel_o,
  output round_key_sel_e round_key_sel_o,
  output key_full_sel_e  key_full_init_sel_o
);

  logic inv;

  assign inv = (op_i == CIPH_INV);

  always_comb begin
    key_words_sel_o = KEY_WORDS_ZERO;
    unique case (key_phase_i)
      // Initial add-round-key, inverse starts from the top words
      KEY_PHASE_INIT: begin
        unique case (key_len_i)
          AES_128: key_words_sel_o = KEY_WORDS_0123;
          AES_192: key_words_sel_o = inv ? KEY_WORDS_2345 : KEY_WORDS_0123;
          AES_256: key_words_sel_o = inv ? KEY_WORDS_4567 : KEY_WORDS_0123;
          default: key_words_sel_o = KEY_WORDS_ZERO;
        endcase
      end
      // Regular and final rounds, forward uses the newest words
      KEY_PHASE_ROUND: begin
        unique case (key_len_i)
          AES_128: key_words_sel_o = KEY_WORDS_0123;
          AES_192: key_words_sel_o = inv ? KEY_WORDS_0123 : KEY_WORDS_2345;
          AES_256: key_words_sel_o = inv ? KEY_WORDS_0123 : KEY_WORDS_4567;
          default: key_words_sel_o = KEY_WORDS_ZERO;
        endcase
      end
      default: key_words_sel_o = KEY_WORDS_ZERO;
    endcase
  end

  // Equivalent inverse cipher needs mixed round keys
  assign round_key_sel_o = inv ? ROUND_KEY_MIXED : ROUND_KEY_DIRECT;

  // Decryption starts from the stored decryption key
  assign key_full_init_sel_o = inv ? KEY_FULL_DEC_INIT : KEY_FULL_ENC_INIT;

endmodule

/* design/cipher_ctrl/cipher_rnd_ctr.sv */
////////////////////////////////////////
// Round counter
// Counts rounds and flags counter faults
////////////////////////////////////////

module cipher_rnd_ctr import cipher_ctrl_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  key_len_e             key_len_i,
  input  logic                 rnd_start_i,
  input  logic                 rnd_inc_i,
  output logic [RND_CTR_W-1:0] rnd_ctr_o,
  output logic                 last_round_o,
  output logic                 rnd_err_o
);

  logic [RND_CTR_W-1:0] rnd_ctr_q;
  logic [RND_CTR_W-1:0] num_rounds_d, num_rounds_q;

  // Round count by key length
  always_comb begin
    unique case (key_len_i)
      AES_128: num_rounds_d = NUM_ROUNDS_128;
      AES_192: num_rounds_d = NUM_ROUNDS_192;
      default: num_rounds_d = NUM_ROUNDS_256;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd_ctr_q    <= '0;
      num_rounds_q <= NUM_ROUNDS_128;
    end else if (rnd_start_i) begin
      rnd_ctr_q    <= '0;
      num_rounds_q <= num_rounds_d;
    end else if (rnd_inc_i) begin
      rnd_ctr_q    <= rnd_ctr_q + 1'b1;
    end
  end

  assign rnd_ctr_o = rnd_ctr_q;

  // Last regular round, the final round follows
  assign last_round_o = rnd_ctr_q >= (num_rounds_q - 1'b1);

  // Counter can never legally pass the round count
  assign rnd_err_o = rnd_ctr_q > num_rounds_q;

  a_start_inc_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rnd_start_i && rnd_inc_i));

endmodule

/* design/cipher_ctrl/cipher_cmd_reg.sv */
////////////////////////////////////////
// Command register
// Holds the accepted command until done
////////////////////////////////////////

module cipher_cmd_reg import cipher_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  cipher_cmd_t cmd_i,
  input  logic        cmd_load_i,
  input  logic        cmd_done_i,
  output cipher_cmd_t cmd_q_o
);

  cipher_cmd_t cmd_d, cmd_q;
  logic        clear_req;

  // Clear commands take priority over crypt and key generation
  assign clear_req = cmd_i.key_clear | cmd_i.data_out_clear;

  always_comb begin
    cmd_d = cmd_q;
    if (cmd_load_i) begin
      cmd_d = cmd_i;
      // Key generation wins over a crypt request
      cmd_d.crypt       = cmd_i.crypt & ~cmd_i.dec_key_gen & ~clear_req;
      cmd_d.dec_key_gen = cmd_i.dec_key_gen & ~clear_req;
    end else if (cmd_done_i) begin
      // Operation and key length stay for the datapath
      cmd_d.crypt          = 1'b0;
      cmd_d.dec_key_gen    = 1'b0;
      cmd_d.key_clear      = 1'b0;
      cmd_d.data_out_clear = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q <= '{op: CIPH_FWD, key_len: AES_128, default: 1'b0};
    end else begin
      cmd_q <= cmd_d;
    end
  end

  assign cmd_q_o = cmd_q;

  a_load_done_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cmd_load_i && cmd_done_i));

endmodule

/* common/cipher_ctrl_pkg.sv */
////////////////////////////////////////
// Cipher control package
// Shared enums, structs and round counts
////////////////////////////////////////

package cipher_ctrl_pkg;

  // Round counter width and round counts per key length
  localparam int unsigned RND_CTR_W = 4;
  localparam logic [RND_CTR_W-1:0] NUM_ROUNDS_128 = 4'd10;
  localparam logic [RND_CTR_W-1:0] NUM_ROUNDS_192 = 4'd12;
  localparam logic [RND_CTR_W-1:0] NUM_ROUNDS_256 = 4'd14;

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // One-hot key length
  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  typedef enum logic [2:0] {
    CIPHER_IDLE,
    CIPHER_INIT,
    CIPHER_ROUND,
    CIPHER_FINISH,
    CIPHER_CLEAR_S,
    CIPHER_CLEAR_KD,
    CIPHER_ERROR
  } cipher_state_e;

  // Which add-round-key word selection applies this cycle
  typedef enum logic [1:0] {
    KEY_PHASE_NONE,
    KEY_PHASE_INIT,
    KEY_PHASE_ROUND
  } key_phase_e;

  ////////////////////////////////////////
  // Datapath selectors
  ////////////////////////////////////////

  typedef enum logic [1:0] {STATE_ROUND, STATE_INIT, STATE_CLEAR} state_sel_e;
  typedef enum logic [1:0] {ADD_RK_INIT, ADD_RK_ROUND, ADD_RK_FINAL} add_rk_sel_e;
  typedef enum logic [1:0] {
    KEY_FULL_ENC_INIT,
    KEY_FULL_DEC_INIT,
    KEY_FULL_ROUND,
    KEY_FULL_CLEAR
  } key_full_sel_e;
  typedef enum logic {KEY_DEC_EXPAND, KEY_DEC_CLEAR} key_dec_sel_e;
  typedef enum logic [1:0] {
    KEY_WORDS_0123,
    KEY_WORDS_2345,
    KEY_WORDS_4567,
    KEY_WORDS_ZERO
  } key_words_sel_e;
  typedef enum logic {ROUND_KEY_DIRECT, ROUND_KEY_MIXED} round_key_sel_e;

  ////////////////////////////////////////
  // Bundled command and control
  ////////////////////////////////////////

  typedef struct packed {
    logic     crypt;
    logic     dec_key_gen;
    logic     key_clear;
    logic     data_out_clear;
    ciph_op_e op;
    key_len_e key_len;
  } cipher_cmd_t;

  typedef struct packed {
    state_sel_e  state_sel;
    logic        state_we;
    add_rk_sel_e add_rk_sel;
    logic        sub_bytes_en;
    logic        sub_bytes_out_ack;
  } state_ctrl_t;

  typedef struct packed {
    key_full_sel_e  key_full_sel;
    logic           key_full_we;
    key_dec_sel_e   key_dec_sel;
    logic           key_dec_we;
    logic           key_expand_en;
    logic           key_expand_out_ack;
    logic           key_expand_clear;
    key_words_sel_e key_words_sel;
    round_key_sel_e round_key_sel;
  } key_ctrl_t;

endpackage
